// File: common/rem_defs.svh
// signed remainder divider widths and step-count constants
`ifndef REM_DEFS_SVH
`define REM_DEFS_SVH

// operand and result width
`define REM_WORD_WIDTH 8

// one extra bit of range so the most negative operand can be negated
`define REM_WORD_WIDTH_LONG (`REM_WORD_WIDTH + 1)

// step counter must hold REM_STEPS_INITIAL
`define REM_STEPS_WIDTH 4

// steps run from long width minus one down to zero
`define REM_STEPS_INITIAL (`REM_WORD_WIDTH_LONG - 1)

`endif

// File: common/rem_pkg.sv
// signed remainder divider types shared by controller, counter and datapath
`default_nettype none

package rem_pkg;

    `include "rem_defs.svh"

    // operand / result word
    typedef logic [`REM_WORD_WIDTH-1:0] word_t;

    // internal word with the extra range bit
    typedef logic [`REM_WORD_WIDTH_LONG-1:0] long_t;

    // division step number
    typedef logic [`REM_STEPS_WIDTH-1:0] step_t;

    // controller states, 2'b01 never reached
    typedef enum logic [1:0] {
        LOAD = 2'b00,
        CALC = 2'b10,
        DONE = 2'b11
    } rem_state_t;

    // controller to datapath and counter
    typedef struct packed {
        logic load;
        logic calc;
        logic first;
    } rem_cmd_t;

    // divisor block to remainder block
    typedef struct packed {
        long_t increment;
        logic  divisor_sign;
        logic  incr_valid;
    } rem_incr_t;

endpackage

`default_nettype wire

// File: hw/rem_fsm.sv
// remainder controller, load/calculate/done FSM driving handshakes and step commands
`timescale 1ns/1ps
`default_nettype none

module rem_fsm import rem_pkg::*; (
    input  logic     clock,
    input  logic     rst,
    input  logic     input_valid,
    output logic     input_ready,
    output logic     output_valid,
    input  logic     output_ready,
    input  logic     last_step,
    input  logic     first_step,
    output rem_cmd_t cmd
);

    rem_state_t state;
    rem_state_t state_next;
    logic       read_outputs;

    // handshake levels straight from state, never from the other side's valid/ready
    always_comb begin
        input_ready  = (state == LOAD);
        output_valid = (state == DONE);
        read_outputs = output_valid && output_ready;
    end

    // step commands for datapath and counter
    always_comb begin
        cmd.load  = input_ready && input_valid;
        // one division step every cycle while calculating
        cmd.calc  = (state == CALC);
        // counter already qualifies with calc
        cmd.first = first_step;
    end

    // LOAD -> CALC -> DONE -> LOAD
    always_comb begin
        state_next = state;
        unique case (state)
            LOAD: if (cmd.load) state_next = CALC;
            CALC: if (last_step) state_next = DONE;
            DONE: if (read_outputs) state_next = LOAD;
            default: state_next = LOAD;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= LOAD;
        end else begin
            state <= state_next;
        end
    end

    // input and output side are mutually exclusive, one division in flight
    a_one_in_flight: assert property (@(posedge clock) disable iff (rst)
        !(input_ready && output_valid));

    // unused encoding 2'b01 must never be entered
    a_legal_state: assert property (@(posedge clock) disable iff (rst)
        state inside {LOAD, CALC, DONE});

endmodule

`default_nettype wire

// File: hw/rem_step_counter.sv
// remainder step counter, counts division steps down and flags first and last
`timescale 1ns/1ps
`default_nettype none

module rem_step_counter import rem_pkg::*; (
    input  logic     clock,
    input  logic     rst,
    input  rem_cmd_t cmd,
    output logic     first_step,
    output logic     last_step
);

    `include "rem_defs.svh"

    localparam step_t STEP_INITIAL = step_t'(`REM_STEPS_INITIAL);

    step_t count;

    // reload on accept, then one decrement per division step
    // holds at zero once the last step is reached
    always_ff @(posedge clock) begin
        if (rst) begin
            count <= STEP_INITIAL;
        end else if (cmd.load) begin
            count <= STEP_INITIAL;
        end else if (cmd.calc && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    // first step only counts while calculating, count also idles at the initial value
    always_comb begin
        first_step = cmd.calc && (count == STEP_INITIAL);
        last_step  = (count == '0);
    end

    // count stays inside the step range
    a_count_range: assert property (@(posedge clock) disable iff (rst)
        count <= STEP_INITIAL);

endmodule

`default_nettype wire

// File: datapath/rem_divisor_shift.sv
// remainder divisor block, shifts the divisor into the increment and detects divide by zero
`timescale 1ns/1ps
`default_nettype none

module rem_divisor_shift import rem_pkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  rem_cmd_t  cmd,
    input  word_t     divisor,
    output rem_incr_t incr,
    output logic      divide_by_zero
);

    `include "rem_defs.svh"

    localparam int MSB = `REM_WORD_WIDTH_LONG - 1;

    long_t divisor_long;
    long_t divisor_reg;
    long_t increment_reg;
    logic  divisor_sign;
    logic  divisor_all_sign_bits;
    logic  divisor_is_zero;

    // sign-extend into the long range
    always_comb begin
        divisor_long = {divisor[`REM_WORD_WIDTH-1], divisor};
    end

    // load does the first shift already
    // each step moves the divisor lsb into the increment msb
    // arithmetic shift written out by hand
    always_ff @(posedge clock) begin
        if (cmd.load) begin
            divisor_sign  <= divisor_long[MSB];
            divisor_reg   <= {divisor_long[MSB], divisor_long[MSB:1]};
            increment_reg <= {divisor_long[0], {(`REM_WORD_WIDTH){1'b0}}};
        end else if (cmd.calc) begin
            divisor_reg   <= {divisor_reg[MSB], divisor_reg[MSB:1]};
            increment_reg <= {divisor_reg[0], increment_reg[MSB:1]};
        end
    end

    // increment usable once only sign bits remain in the divisor
    // and enough bits have moved over to give it the divisor's sign
    always_comb begin
        if (divisor_sign) begin
            divisor_all_sign_bits = (divisor_reg == '1);
        end else begin
            divisor_all_sign_bits = (divisor_reg == '0);
        end
        incr.increment    = increment_reg;
        incr.divisor_sign = divisor_sign;
        incr.incr_valid   = divisor_all_sign_bits && (increment_reg[MSB] == divisor_sign);
    end

    // undo the load-time shift to see the original divisor
    always_comb begin
        divisor_is_zero = ({divisor_reg[`REM_WORD_WIDTH-1:0], increment_reg[MSB]} == '0);
    end

    // flag sampled on the first step, dropped when new operands arrive
    always_ff @(posedge clock) begin
        if (rst) begin
            divide_by_zero <= 1'b0;
        end else if (cmd.load) begin
            divide_by_zero <= 1'b0;
        end else if (cmd.first) begin
            divide_by_zero <= divisor_is_zero;
        end
    end

endmodule

`default_nettype wire

// File: datapath/rem_remainder_acc.sv
// remainder accumulator, moves the dividend toward zero and refuses overshooting steps
`timescale 1ns/1ps
`default_nettype none

module rem_remainder_acc import rem_pkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  rem_cmd_t  cmd,
    input  word_t     dividend,
    input  rem_incr_t incr,
    output word_t     remainder
);

    `include "rem_defs.svh"

    localparam int MSB = `REM_WORD_WIDTH_LONG - 1;

    long_t dividend_long;
    long_t remainder_reg;
    logic  dividend_sign;
    logic  subtract;
    long_t operand_b;
    long_t remainder_next;
    logic  remainder_overflow;
    logic  remainder_next_valid;
    logic  step_ok;

    always_comb begin
        dividend_long = {dividend[`REM_WORD_WIDTH-1], dividend};
    end

    // same signs means subtract to approach zero, else add
    // subtraction as add of the inverted increment plus carry in
    always_comb begin
        subtract           = (incr.divisor_sign == dividend_sign);
        operand_b          = subtract ? ~incr.increment : incr.increment;
        remainder_next     = remainder_reg + operand_b + long_t'(subtract);
        // signed overflow when both addends agree in sign and the sum does not
        remainder_overflow = (remainder_reg[MSB] == operand_b[MSB])
                          && (remainder_next[MSB] != remainder_reg[MSB]);
    end

    // an overshoot past zero flips the sign, that step is skipped
    always_comb begin
        remainder_next_valid = ((remainder_next[MSB] == dividend_sign) && !remainder_overflow)
                            || (remainder_next == '0);
        step_ok              = cmd.calc && incr.incr_valid && remainder_next_valid;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            remainder_reg <= '0;
            dividend_sign <= 1'b0;
        end else if (cmd.load) begin
            remainder_reg <= dividend_long;
            dividend_sign <= dividend_long[MSB];
        end else if (step_ok) begin
            remainder_reg <= remainder_next;
        end
    end

    // drop the extra range bit on the way out
    always_comb begin
        remainder = remainder_reg[`REM_WORD_WIDTH-1:0];
    end

    // remainder never crosses zero into the other sign
    a_remainder_sign: assert property (@(posedge clock) disable iff (rst)
        (remainder_reg[MSB] == dividend_sign) || (remainder_reg == '0));

endmodule

`default_nettype wire

// File: hw/rem_top.sv
// signed remainder divider top, controller, step counter and datapath
`timescale 1ns/1ps
`default_nettype none

module rem_top import rem_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  logic  input_valid,
    output logic  input_ready,
    input  word_t dividend,
    input  word_t divisor,
    output logic  output_valid,
    input  logic  output_ready,
    output word_t remainder,
    output logic  divide_by_zero
);

    rem_cmd_t  cmd;
    rem_incr_t incr;
    logic      first_step;
    logic      last_step;

    rem_fsm u_rem_fsm (
        .clock        (clock),
        .rst          (rst),
        .input_valid  (input_valid),
        .input_ready  (input_ready),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .last_step    (last_step),
        .first_step   (first_step),
        .cmd          (cmd)
    );

    rem_step_counter u_rem_step_counter (
        .clock      (clock),
        .rst        (rst),
        .cmd        (cmd),
        .first_step (first_step),
        .last_step  (last_step)
    );

    // divisor side produces the increment for the remainder side
    rem_divisor_shift u_rem_divisor_shift (
        .clock          (clock),
        .rst            (rst),
        .cmd            (cmd),
        .divisor        (divisor),
        .incr           (incr),
        .divide_by_zero (divide_by_zero)
    );

    rem_remainder_acc u_rem_remainder_acc (
        .clock     (clock),
        .rst       (rst),
        .cmd       (cmd),
        .dividend  (dividend),
        .incr      (incr),
        .remainder (remainder)
    );

endmodule

`default_nettype wire

// File: dv/rem_tb.sv
// signed remainder divider testbench, directed and random divisions checked by assertions
`timescale 1ns/1ps
`default_nettype none

module rem_tb import rem_pkg::*; ();

    localparam int CLK_PERIOD_NS = 4;
    localparam int NUM_RANDOM    = 200;
    localparam int NUM_DIVS      = 11 + NUM_RANDOM;
    // accept, nine steps, up to seven stall cycles and edge alignment
    localparam int MAX_DIV_CYCLES = 20;
    localparam int WATCHDOG_NS    = 2 * NUM_DIVS * MAX_DIV_CYCLES * CLK_PERIOD_NS;

    logic  clock;
    logic  rst;
    logic  input_valid;
    logic  input_ready;
    word_t dividend;
    word_t divisor;
    logic  output_valid;
    logic  output_ready;
    word_t remainder;
    logic  divide_by_zero;

    // expected result of the division in flight
    string       test_name;
    word_t       exp_rem;
    logic        exp_dbz;
    logic [15:0] lfsr_state;

    rem_top u_rem_top (
        .clock          (clock),
        .rst            (rst),
        .input_valid    (input_valid),
        .input_ready    (input_ready),
        .dividend       (dividend),
        .divisor        (divisor),
        .output_valid   (output_valid),
        .output_ready   (output_ready),
        .remainder      (remainder),
        .divide_by_zero (divide_by_zero)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clock = ~clock;
    end

    // print the reason, then the fail message, then stop
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
    endtask

    // truncating remainder, sign follows the dividend; zero divisor returns the dividend
    function automatic word_t model_rem(input word_t a, input word_t b);
        int ai;
        int bi;
        ai = $signed(a);
        bi = $signed(b);
        if (bi == 0) begin
            return a;
        end
        return word_t'(ai % bi);
    endfunction

    // one full division with a random stall before the result is read
    task automatic do_division(input string name, input word_t a, input word_t b,
                               input word_t exp_r, input logic exp_z);
        logic [7:0] stall;
        take_bits(3, stall);
        while (!input_ready) begin
            @(negedge clock);
        end
        test_name   = name;
        exp_rem     = exp_r;
        exp_dbz     = exp_z;
        dividend    = a;
        divisor     = b;
        input_valid = 1'b1;
        @(negedge clock);
        input_valid = 1'b0;
        while (!output_valid) begin
            @(negedge clock);
        end
        repeat (stall) @(negedge clock);
        output_ready = 1'b1;
        @(negedge clock);
        output_ready = 1'b0;
    endtask

    task automatic modeled_division(input string name, input word_t a, input word_t b);
        do_division(name, a, b, model_rem(a, b), (b == '0));
    endtask

    // idle state right after reset
    a_reset_state: assert property (@(posedge clock)
        $fell(rst) |-> (input_ready && !output_valid && !divide_by_zero))
        else fail_run("idle state wrong after reset release");

    a_remainder: assert property (@(posedge clock) disable iff (rst)
        (output_valid && output_ready) |-> (remainder == exp_rem))
        else fail_run($sformatf("ERROR %s: remainder expected %0d, actual %0d", test_name,
                                $signed(exp_rem), $signed($sampled(remainder))));

    a_divide_by_zero: assert property (@(posedge clock) disable iff (rst)
        (output_valid && output_ready) |-> (divide_by_zero == exp_dbz))
        else fail_run($sformatf("ERROR %s: divide_by_zero expected %0b, actual %0b",
                                test_name, exp_dbz, $sampled(divide_by_zero)));

    // back-pressure holds the result and blocks new operands
    a_stall_hold: assert property (@(posedge clock) disable iff (rst)
        (output_valid && !output_ready) |=> (output_valid && !input_ready
                                             && $stable(divide_by_zero)))
        else fail_run("output_valid, input_ready or divide_by_zero moved during a stall");

    a_stall_remainder: assert property (@(posedge clock) disable iff (rst)
        (output_valid && !output_ready) |=> (remainder == exp_rem))
        else fail_run($sformatf("ERROR %s: stalled remainder expected %0d, actual %0d",
                                test_name, $signed(exp_rem),
                                $signed($sampled(remainder))));

    // nine step edges between acceptance and a valid result
    a_latency: assert property (@(posedge clock) disable iff (rst)
        (input_valid && input_ready) |=> (!output_valid) [*9] ##1 output_valid)
        else fail_run("output_valid did not rise 9 edges after the input handshake");

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before all divisions completed");
    end

    initial begin
        logic [7:0] ra;
        logic [7:0] rb;
        rst          = 1'b1;
        input_valid  = 1'b0;
        output_ready = 1'b0;
        dividend     = '0;
        divisor      = '0;
        exp_rem      = '0;
        exp_dbz      = 1'b0;
        test_name    = "reset";
        lfsr_state   = 16'd7;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        @(negedge clock);

        // sign and zero combinations
        do_division("sign_zero", 8'sd7, 8'sd2, 8'sd1, 1'b0);
        do_division("sign_zero", -8'sd7, 8'sd2, -8'sd1, 1'b0);
        do_division("sign_zero", 8'sd7, -8'sd2, 8'sd1, 1'b0);
        do_division("sign_zero", -8'sd7, -8'sd2, -8'sd1, 1'b0);
        do_division("sign_zero", 8'sd6, 8'sd3, 8'sd0, 1'b0);
        do_division("sign_zero", -8'sd6, 8'sd3, 8'sd0, 1'b0);
        do_division("sign_zero", 8'sd0, 8'sd5, 8'sd0, 1'b0);
        do_division("sign_zero", 8'sd5, 8'sd0, 8'sd5, 1'b1);
        do_division("sign_zero", -8'sd5, 8'sd0, -8'sd5, 1'b1);
        do_division("sign_zero", 8'sd0, 8'sd0, 8'sd0, 1'b1);
        do_division("sign_zero", 8'sd3, 8'sd7, 8'sd3, 1'b0);

        // most negative operand first, then free random pairs
        for (int i = 0; i < NUM_RANDOM; i++) begin
            take_bits(8, ra);
            take_bits(8, rb);
            case (i)
                0: modeled_division("most_negative", 8'h80, 8'h01);
                1: modeled_division("most_negative", 8'h80, 8'hff);
                2: modeled_division("most_negative", 8'h80, 8'h80);
                3: modeled_division("most_negative", ra, 8'h80);
                default: modeled_division("random", ra, rb);
            endcase
        end

        repeat (4) @(negedge clock);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
common/rem_pkg.sv
hw/rem_fsm.sv
hw/rem_step_counter.sv
datapath/rem_divisor_shift.sv
datapath/rem_remainder_acc.sv
hw/rem_top.sv
dv/rem_tb.sv
